/* bench/tb_target_model.sv */
`default_nettype none

module tb_target_model import xbar_chan_pkg::*; #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32,
	parameter int TID_W  = 6
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  req_valid_i,
	output logic                  req_ready_o,
	input  logic [ADDR_W-1:0]     req_addr_i,
	input  logic                  req_we_i,
	input  logic [DATA_W-1:0]     req_wdata_i,
	input  logic [DATA_W/8-1:0]   req_strb_i,
	input  logic [TID_W-1:0]      req_id_i,
	output logic                  resp_valid_o,
	input  logic                  resp_ready_i,
	output logic [DATA_W-1:0]     resp_rdata_o,
	output logic [1:0]            resp_resp_o,
	output logic [TID_W-1:0]      resp_id_o,
	output logic                  stall_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [DATA_W-1:0] mem [1024];
	logic [15:0]       lfsr_q;

	// taps 16, 14, 13 and 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	initial begin
		int                cnt;
		int                delay;
		logic [9:0]        idx;
		logic              we;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W/8-1:0] strb;
		logic [TID_W-1:0]  id;
		lfsr_q       = 16'd45279;
		stall_o      = 1'b0;
		req_ready_o  = 1'b0;
		resp_valid_o = 1'b0;
		resp_rdata_o = '0;
		resp_resp_o  = RESP_OKAY;
		resp_id_o    = '0;
		for (int k = 0; k < 1024; k++) begin
			mem[k] = DATA_W'(k * 32'h9E3779B1);
		end
		@(posedge rst_n_i);
		forever begin
			cnt = 0;
			@(negedge clk);
			req_ready_o = lfsr_bit();
			@(posedge clk);
			while (!(req_valid_i && req_ready_o)) begin
				cnt++;
				if (cnt > 20000) begin
					stall_o = 1'b1;
				end
				@(negedge clk);
				req_ready_o = lfsr_bit();
				@(posedge clk);
			end
			idx   = req_addr_i[11:2];
			we    = req_we_i;
			wdata = req_wdata_i;
			strb  = req_strb_i;
			id    = req_id_i;
			@(negedge clk);
			req_ready_o = 1'b0;
			if (we) begin
				for (int b = 0; b < DATA_W / 8; b++) begin
					if (strb[b]) begin
						mem[idx][8*b +: 8] = wdata[8*b +: 8];
					end
				end
			end
			delay = int'({lfsr_bit(), lfsr_bit()});
			repeat (delay) @(negedge clk);
			resp_valid_o = 1'b1;
			resp_rdata_o = we ? '0 : mem[idx];
			resp_resp_o  = RESP_OKAY;
			resp_id_o    = id;
			cnt = 0;
			@(posedge clk);
			while (!resp_ready_i) begin
				cnt++;
				if (cnt > 2000) begin
					stall_o = 1'b1;
				end
				@(posedge clk);
			end
			@(negedge clk);
			resp_valid_o = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* bench/tb_xbar_node.sv */
`default_nettype none

module tb_xbar_node import xbar_chan_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NI = 3;
	localparam int NT = 3;
	localparam int AW = 32;
	localparam int DW = 32;
	localparam int IW = 4;
	localparam int SW = 4;
	localparam int TW = 6;

	logic clk;
	logic rst_n;
	logic [NI-1:0]         init_req_valid_i, init_req_ready_o, init_req_we_i;
	logic [NI-1:0][AW-1:0] init_req_addr_i;
	logic [NI-1:0][DW-1:0] init_req_wdata_i;
	logic [NI-1:0][SW-1:0] init_req_strb_i;
	logic [NI-1:0][IW-1:0] init_req_id_i;
	logic [NI-1:0]         init_resp_valid_o, init_resp_ready_i;
	logic [NI-1:0][DW-1:0] init_resp_rdata_o;
	logic [NI-1:0][1:0]    init_resp_resp_o;
	logic [NI-1:0][IW-1:0] init_resp_id_o;
	logic [NT-1:0]         targ_req_valid_o, targ_req_ready_i, targ_req_we_o;
	logic [NT-1:0][AW-1:0] targ_req_addr_o;
	logic [NT-1:0][DW-1:0] targ_req_wdata_o;
	logic [NT-1:0][SW-1:0] targ_req_strb_o;
	logic [NT-1:0][TW-1:0] targ_req_id_o;
	logic [NT-1:0]         targ_resp_valid_i, targ_resp_ready_o;
	logic [NT-1:0][DW-1:0] targ_resp_rdata_i;
	logic [NT-1:0][1:0]    targ_resp_resp_i;
	logic [NT-1:0][TW-1:0] targ_resp_id_i;
	logic [NT-1:0][AW-1:0] start_addr, end_addr;
	logic [NT-1:0]         stall;
	logic [15:0]           lfsr_q = 16'd45279;

	xbar_node_top DUT (
		.clk(clk), .rst_n_i(rst_n),
		.init_req_valid_i(init_req_valid_i), .init_req_ready_o(init_req_ready_o),
		.init_req_addr_i(init_req_addr_i), .init_req_we_i(init_req_we_i),
		.init_req_wdata_i(init_req_wdata_i), .init_req_strb_i(init_req_strb_i),
		.init_req_id_i(init_req_id_i),
		.init_resp_valid_o(init_resp_valid_o), .init_resp_ready_i(init_resp_ready_i),
		.init_resp_rdata_o(init_resp_rdata_o), .init_resp_resp_o(init_resp_resp_o),
		.init_resp_id_o(init_resp_id_o),
		.targ_req_valid_o(targ_req_valid_o), .targ_req_ready_i(targ_req_ready_i),
		.targ_req_addr_o(targ_req_addr_o), .targ_req_we_o(targ_req_we_o),
		.targ_req_wdata_o(targ_req_wdata_o), .targ_req_strb_o(targ_req_strb_o),
		.targ_req_id_o(targ_req_id_o),
		.targ_resp_valid_i(targ_resp_valid_i), .targ_resp_ready_o(targ_resp_ready_o),
		.targ_resp_rdata_i(targ_resp_rdata_i), .targ_resp_resp_i(targ_resp_resp_i),
		.targ_resp_id_i(targ_resp_id_i),
		.start_addr_i(start_addr), .end_addr_i(end_addr)
	);

	for (genvar t = 0; t < NT; t++) begin : g_targ
		tb_target_model #(.ADDR_W(AW), .DATA_W(DW), .TID_W(TW)) u_targ (
			.clk(clk), .rst_n_i(rst_n),
			.req_valid_i(targ_req_valid_o[t]), .req_ready_o(targ_req_ready_i[t]),
			.req_addr_i(targ_req_addr_o[t]), .req_we_i(targ_req_we_o[t]),
			.req_wdata_i(targ_req_wdata_o[t]), .req_strb_i(targ_req_strb_o[t]),
			.req_id_i(targ_req_id_o[t]),
			.resp_valid_o(targ_resp_valid_i[t]), .resp_ready_i(targ_resp_ready_o[t]),
			.resp_rdata_o(targ_resp_rdata_i[t]), .resp_resp_o(targ_resp_resp_i[t]),
			.resp_id_o(targ_resp_id_i[t]), .stall_o(stall[t])
		);
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else
			report_error($sformatf("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act));
	endtask

	function automatic logic in_range(input logic [AW-1:0] a, input int t);
		return a >= start_addr[t] && a <= end_addr[t];
	endfunction

	// one request, then its response under random ready gaps
	task automatic transact(input int i, input logic [AW-1:0] addr, input logic we,
		input logic [DW-1:0] wdata, input logic [SW-1:0] strb, input logic [IW-1:0] id,
		input logic [DW-1:0] exp_rdata, input resp_e exp_resp);
		int cnt;
		@(negedge clk);
		init_req_valid_i[i] = 1'b1;
		init_req_addr_i[i]  = addr;
		init_req_we_i[i]    = we;
		init_req_wdata_i[i] = wdata;
		init_req_strb_i[i]  = strb;
		init_req_id_i[i]    = id;
		cnt = 0;
		@(posedge clk);
		while (!init_req_ready_o[i]) begin
			cnt++;
			if (cnt > 2000) report_error($sformatf("initiator %0d request never accepted", i));
			@(posedge clk);
		end
		@(negedge clk);
		init_req_valid_i[i]  = 1'b0;
		init_resp_ready_i[i] = lfsr_bit();
		cnt = 0;
		@(posedge clk);
		while (!(init_resp_valid_o[i] && init_resp_ready_i[i])) begin
			cnt++;
			if (cnt > 2000) report_error($sformatf("initiator %0d response never arrived", i));
			@(negedge clk);
			init_resp_ready_i[i] = lfsr_bit();
			@(posedge clk);
		end
		check_value("init_resp_resp_o", 64'(exp_resp), 64'(init_resp_resp_o[i]));
		check_value("init_resp_rdata_o", 64'(exp_rdata), 64'(init_resp_rdata_o[i]));
		check_value("init_resp_id_o", 64'(id), 64'(init_resp_id_o[i]));
		@(negedge clk);
		init_resp_ready_i[i] = 1'b0;
	endtask

	task automatic run_initiator(input int i);
		logic [AW-1:0] addr;
		logic [DW-1:0] d0, d1;
		logic [IW-1:0] id;
		for (int t = 0; t < NT; t++) begin
			addr = start_addr[t] + 32'(i << 8) + (rand_bits(4) << 2);
			id   = 4'(rand_bits(4));
			d0   = rand_bits(32);
			d1   = rand_bits(32);
			transact(i, addr, 1'b1, d0, 4'hF, id, '0, RESP_OKAY);
			transact(i, addr, 1'b1, d1, 4'b0101, 4'(id + 4'd1), '0, RESP_OKAY);
			// bytes 0 and 2 come from the second write
			transact(i, addr, 1'b0, '0, '0, 4'(id + 4'd2),
				(d1 & 32'h00FF00FF) | (d0 & 32'hFF00FF00), RESP_OKAY);
		end
		transact(i, 32'h8000_0000 | rand_bits(16), 1'b1, rand_bits(32), 4'hF, 4'(i),
			'0, RESP_DECERR);
	endtask

	logic [NT-1:0]                    tq_hold = '0;
	logic [NT-1:0][AW+1+DW+SW+TW-1:0] tq_pl;
	logic [NI-1:0]                    rp_hold = '0;
	logic [NI-1:0][DW+2+IW-1:0]       rp_pl;
	int skip [NT][NI];
	int outstanding [NI];

	always @(posedge clk) begin
		int src;
		if (rst_n) begin
			for (int t = 0; t < NT; t++) begin
				if (tq_hold[t])
					assert (targ_req_valid_o[t] && tq_pl[t] == {targ_req_addr_o[t],
						targ_req_we_o[t], targ_req_wdata_o[t], targ_req_strb_o[t],
						targ_req_id_o[t]})
					else report_error($sformatf("target %0d request changed before handshake", t));
				if (targ_req_valid_o[t])
					assert (in_range(targ_req_addr_o[t], t))
					else report_error($sformatf("target %0d got an address outside its range", t));
				tq_hold[t] = targ_req_valid_o[t] && !targ_req_ready_i[t];
				tq_pl[t]   = {targ_req_addr_o[t], targ_req_we_o[t], targ_req_wdata_o[t],
					targ_req_strb_o[t], targ_req_id_o[t]};
				if (targ_req_valid_o[t] && targ_req_ready_i[t]) begin
					// only the granted initiator sees ready, so one handshake falls in this range
					src = -1;
					for (int j = 0; j < NI; j++) begin
						if (init_req_valid_i[j] && init_req_ready_o[j]
							&& in_range(init_req_addr_i[j], t))
							src = j;
					end
					assert (src >= 0)
					else report_error("target request without a matching initiator handshake");
					check_value("targ_req_id_o", 64'({src[1:0], init_req_id_i[src]}),
						64'(targ_req_id_o[t]));
					check_value("targ_req_addr_o", 64'(init_req_addr_i[src]),
						64'(targ_req_addr_o[t]));
					check_value("targ_req_we_o", 64'(init_req_we_i[src]),
						64'(targ_req_we_o[t]));
					check_value("targ_req_wdata_o", 64'(init_req_wdata_i[src]),
						64'(targ_req_wdata_o[t]));
					check_value("targ_req_strb_o", 64'(init_req_strb_i[src]),
						64'(targ_req_strb_o[t]));
					for (int j = 0; j < NI; j++) begin
						if (j != src && init_req_valid_i[j] && in_range(init_req_addr_i[j], t))
							skip[t][j]++;
						else
							skip[t][j] = 0;
						assert (skip[t][j] < NI)
						else report_error($sformatf("initiator %0d starved at target %0d", j, t));
					end
				end
			end
			for (int i = 0; i < NI; i++) begin
				if (rp_hold[i])
					assert (init_resp_valid_o[i] && rp_pl[i] == {init_resp_rdata_o[i],
						init_resp_resp_o[i], init_resp_id_o[i]})
					else report_error($sformatf("response to %0d changed before handshake", i));
				rp_hold[i] = init_resp_valid_o[i] && !init_resp_ready_i[i];
				rp_pl[i]   = {init_resp_rdata_o[i], init_resp_resp_o[i], init_resp_id_o[i]};
				if (init_req_valid_i[i] && init_req_ready_o[i]) outstanding[i]++;
				if (init_resp_valid_o[i] && init_resp_ready_i[i]) begin
					assert (outstanding[i] > 0)
					else report_error($sformatf("initiator %0d got an extra response", i));
					outstanding[i]--;
				end
			end
			if (|stall) report_error("a target model waited too long on the DUT");
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n             = 1'b0;
		init_req_valid_i  = '0;
		init_req_addr_i   = '0;
		init_req_we_i     = '0;
		init_req_wdata_i  = '0;
		init_req_strb_i   = '0;
		init_req_id_i     = '0;
		init_resp_ready_i = '0;
		for (int t = 0; t < NT; t++) begin
			start_addr[t] = 32'(t * 32'h1000);
			end_addr[t]   = 32'(t * 32'h1000 + 32'h0FFF);
		end
		// requests held through reset must reach no target and raise no error response
		init_req_addr_i[0] = start_addr[0];
		init_req_addr_i[1] = start_addr[1];
		init_req_addr_i[2] = 32'h8000_0000;
		init_req_valid_i   = '1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (targ_req_valid_o == '0 && init_resp_valid_o == '0)
		else report_error("a valid output is high at the end of reset");
		init_req_valid_i = '0;
		rst_n = 1'b1;
		fork
			run_initiator(0);
			run_initiator(1);
			run_initiator(2);
		join
		repeat (2) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/req_decoder.sv */
`default_nettype none

module req_decoder import xbar_chan_pkg::*; #(
	parameter int NB_TARG,
	parameter int ADDR_W,
	parameter int ID_W
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	xbar_req_if.dst                         init_req,
	input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
	input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i,
	output logic [NB_TARG-1:0]              sel_valid_o,
	input  logic [NB_TARG-1:0]              sel_ready_i,
	xbar_resp_if.src                        err_resp
);
	logic [ADDR_W-1:0]  addr;
	logic [NB_TARG-1:0] hit;
	logic               match;
	logic               miss;
	logic               err_pend_q;
	logic [ID_W-1:0]    err_id_q;

	assign addr = init_req.payload.addr;

	// ranges are inclusive, overlapping ranges resolve to the lowest target
	always_comb begin
		hit   = '0;
		match = 1'b0;
		for (int t = 0; t < NB_TARG; t++) begin
			if (!match && addr >= start_addr_i[t] && addr <= end_addr_i[t]) begin
				hit[t] = 1'b1;
				match  = 1'b1;
			end
		end
	end

	assign miss = !match;

	// nothing goes out to the targets while an error response is still waiting
	assign sel_valid_o    = (init_req.valid && !err_pend_q) ? hit : '0;
	assign init_req.ready = !err_pend_q && (miss || |(hit & sel_ready_i));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_pend_q <= 1'b0;
		end else if (init_req.valid && init_req.ready && miss) begin
			err_pend_q <= 1'b1;
		end else if (err_resp.valid && err_resp.ready) begin
			err_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (init_req.valid && init_req.ready && miss) begin
			err_id_q <= init_req.payload.id;
		end
	end

	assign err_resp.valid   = err_pend_q;
	assign err_resp.payload = '{rdata: '0, resp: RESP_DECERR, id: err_id_q};

endmodule

`default_nettype wire

/* rtl/resp_switch.sv */
`default_nettype none

module resp_switch import xbar_cfg_pkg::*; import xbar_chan_pkg::*; #(
	parameter int NB_INIT,
	parameter int NB_TARG,
	parameter int DATA_W,
	parameter int ID_W
) (
	input  logic     clk,
	input  logic     rst_n_i,
	xbar_resp_if.dst targ_resp [NB_TARG],
	xbar_resp_if.dst err_resp  [NB_INIT],
	xbar_resp_if.src init_resp [NB_INIT]
);
	localparam int IDX_W   = idx_width(NB_INIT);
	localparam int TID_W   = ID_W + IDX_W;
	localparam int TRESP_W = DATA_W + $bits(resp_e) + TID_W;
	localparam int IRESP_W = DATA_W + $bits(resp_e) + ID_W;

	logic [NB_TARG-1:0]              t_valid;
	logic [NB_TARG-1:0][TRESP_W-1:0] t_pl;
	logic [NB_TARG-1:0][IDX_W-1:0]   t_idx;
	logic [NB_TARG-1:0][NB_INIT-1:0] t_rdy;

	for (genvar t = 0; t < NB_TARG; t++) begin : g_targ
		assign t_valid[t]      = targ_resp[t].valid;
		assign t_pl[t]         = targ_resp[t].payload;
		assign t_idx[t]        = t_pl[t][ID_W +: IDX_W];
		assign targ_resp[t].ready = |t_rdy[t];
	end

	for (genvar i = 0; i < NB_INIT; i++) begin : g_init
		// sources are the targets followed by this initiator's own decode error
		logic [NB_TARG:0]   req;
		logic [NB_TARG:0]   gnt;
		logic               done;
		logic [TRESP_W-1:0] tsel;
		logic [IRESP_W-1:0] stripped;

		for (genvar t = 0; t < NB_TARG; t++) begin : g_src
			assign req[t]      = t_valid[t] && (t_idx[t] == IDX_W'(i));
			assign t_rdy[t][i] = gnt[t] && init_resp[i].ready;
		end
		assign req[NB_TARG] = err_resp[i].valid;

		assign done = init_resp[i].valid && init_resp[i].ready;

		rr_arbiter #(
			.N(NB_TARG + 1)
		) u_arb (
			.clk    (clk),
			.rst_n_i(rst_n_i),
			.req_i  (req),
			.done_i (done),
			.gnt_o  (gnt)
		);

		always_comb begin
			tsel = '0;
			for (int t = 0; t < NB_TARG; t++) begin
				if (gnt[t]) begin
					tsel = t_pl[t];
				end
			end
		end

		// the initiator index is dropped on the way back
		assign stripped = {tsel[TRESP_W-1:TID_W], tsel[ID_W-1:0]};

		assign init_resp[i].valid   = |(gnt & req);
		assign init_resp[i].payload = gnt[NB_TARG] ? err_resp[i].payload : stripped;
		assign err_resp[i].ready    = gnt[NB_TARG] && init_resp[i].ready;
	end

endmodule

`default_nettype wire

/* rtl/rr_arbiter.sv */
`default_nettype none

module rr_arbiter import xbar_cfg_pkg::*; #(
	parameter int N
) (
	input  logic         clk,
	input  logic         rst_n_i,
	input  logic [N-1:0] req_i,
	input  logic         done_i,
	output logic [N-1:0] gnt_o
);
	localparam int PTR_W = idx_width(N);

	logic [PTR_W-1:0] ptr_q;
	logic [N-1:0]     gnt_q;
	logic [N-1:0]     cand;
	logic [N-1:0]     pick;
	logic [PTR_W-1:0] pick_idx;
	logic             found;

	// the requester finishing this cycle may drop its request, so it sits out one round
	assign cand = req_i & ~(done_i ? gnt_q : '0);

	always_comb begin
		int idx;
		pick     = '0;
		pick_idx = '0;
		found    = 1'b0;
		for (int k = 0; k < N; k++) begin
			idx = (int'(ptr_q) + k) % N;
			if (!found && cand[idx]) begin
				found       = 1'b1;
				pick[idx]   = 1'b1;
				pick_idx    = PTR_W'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt_q <= '0;
			ptr_q <= '0;
		end else if (gnt_q == '0 || done_i) begin
			gnt_q <= pick;
			if (found) begin
				ptr_q <= (pick_idx == PTR_W'(N - 1)) ? '0 : pick_idx + 1'b1;
			end
		end
	end

	assign gnt_o = gnt_q;

endmodule

`default_nettype wire

/* rtl/target_arbiter.sv */
`default_nettype none

module target_arbiter import xbar_cfg_pkg::*; #(
	parameter int NB_INIT,
	parameter int ADDR_W,
	parameter int DATA_W,
	parameter int ID_W
) (
	input  logic                                                  clk,
	input  logic                                                  rst_n_i,
	input  logic [NB_INIT-1:0]                                    req_valid_i,
	output logic [NB_INIT-1:0]                                    req_ready_o,
	input  logic [NB_INIT-1:0][ADDR_W+1+DATA_W+DATA_W/8+ID_W-1:0] init_req_data_i,
	xbar_req_if.src                                               targ_req
);
	localparam int IDX_W = idx_width(NB_INIT);
	localparam int REQ_W = ADDR_W + 1 + DATA_W + DATA_W / 8 + ID_W;

	logic [NB_INIT-1:0] gnt;
	logic [REQ_W-1:0]   sel;
	logic [IDX_W-1:0]   sel_idx;

	rr_arbiter #(
		.N(NB_INIT)
	) u_arb (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.req_i  (req_valid_i),
		.done_i (targ_req.valid && targ_req.ready),
		.gnt_o  (gnt)
	);

	always_comb begin
		sel     = '0;
		sel_idx = '0;
		for (int i = 0; i < NB_INIT; i++) begin
			if (gnt[i]) begin
				sel     = init_req_data_i[i];
				sel_idx = IDX_W'(i);
			end
		end
	end

	assign targ_req.valid = |(gnt & req_valid_i);

	// id is the lowest field, so the initiator index slots in just above it
	assign targ_req.payload = {sel[REQ_W-1:ID_W], sel_idx, sel[ID_W-1:0]};

	assign req_ready_o = gnt & {NB_INIT{targ_req.ready}};

endmodule

`default_nettype wire

/* rtl/xbar_cfg_pkg.sv */
`default_nettype none

package xbar_cfg_pkg;

	// port counts of the node
	localparam int NB_INIT = 3;
	localparam int NB_TARG = 3;

	// payload widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W   = 4;

	// width of an index into n ports, never narrower than one bit
	function automatic int idx_width(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

`default_nettype wire

/* rtl/xbar_chan_pkg.sv */
`default_nettype none

package xbar_chan_pkg;

	// response codes keep the AXI encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage

`default_nettype wire

/* rtl/xbar_if.sv */
`default_nettype none

interface xbar_req_if #(
	parameter int ADDR_W,
	parameter int DATA_W,
	parameter int ID_W
);
	localparam int STRB_W = DATA_W / 8;

	// id sits in the low bits so that widening inserts the index right above it
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              we;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
		logic [ID_W-1:0]   id;
	} req_t;

	logic valid;
	logic ready;
	req_t payload;

	modport src (output valid, output payload, input ready);
	modport dst (input valid, input payload, output ready);
endinterface

interface xbar_resp_if import xbar_chan_pkg::*; #(
	parameter int DATA_W,
	parameter int ID_W
);
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		resp_e             resp;
		logic [ID_W-1:0]   id;
	} resp_t;

	logic  valid;
	logic  ready;
	resp_t payload;

	modport src (output valid, output payload, input ready);
	modport dst (input valid, input payload, output ready);
endinterface

`default_nettype wire

/* rtl/xbar_node_top.sv */
`default_nettype none

module xbar_node_top import xbar_cfg_pkg::*; #(
	parameter  int NB_INIT = xbar_cfg_pkg::NB_INIT,
	parameter  int NB_TARG = xbar_cfg_pkg::NB_TARG,
	parameter  int ADDR_W  = xbar_cfg_pkg::ADDR_W,
	parameter  int DATA_W  = xbar_cfg_pkg::DATA_W,
	parameter  int ID_W    = xbar_cfg_pkg::ID_W,
	localparam int STRB_W  = DATA_W / 8,
	localparam int TID_W   = ID_W + idx_width(NB_INIT)
) (
	input  logic                            clk,
	input  logic                            rst_n_i,

	input  logic [NB_INIT-1:0]              init_req_valid_i,
	output logic [NB_INIT-1:0]              init_req_ready_o,
	input  logic [NB_INIT-1:0][ADDR_W-1:0] init_req_addr_i,
	input  logic [NB_INIT-1:0]              init_req_we_i,
	input  logic [NB_INIT-1:0][DATA_W-1:0] init_req_wdata_i,
	input  logic [NB_INIT-1:0][STRB_W-1:0] init_req_strb_i,
	input  logic [NB_INIT-1:0][ID_W-1:0]   init_req_id_i,

	output logic [NB_INIT-1:0]              init_resp_valid_o,
	input  logic [NB_INIT-1:0]              init_resp_ready_i,
	output logic [NB_INIT-1:0][DATA_W-1:0] init_resp_rdata_o,
	output logic [NB_INIT-1:0][1:0]        init_resp_resp_o,
	output logic [NB_INIT-1:0][ID_W-1:0]   init_resp_id_o,

	output logic [NB_TARG-1:0]              targ_req_valid_o,
	input  logic [NB_TARG-1:0]              targ_req_ready_i,
	output logic [NB_TARG-1:0][ADDR_W-1:0] targ_req_addr_o,
	output logic [NB_TARG-1:0]              targ_req_we_o,
	output logic [NB_TARG-1:0][DATA_W-1:0] targ_req_wdata_o,
	output logic [NB_TARG-1:0][STRB_W-1:0] targ_req_strb_o,
	output logic [NB_TARG-1:0][TID_W-1:0]  targ_req_id_o,

	input  logic [NB_TARG-1:0]              targ_resp_valid_i,
	output logic [NB_TARG-1:0]              targ_resp_ready_o,
	input  logic [NB_TARG-1:0][DATA_W-1:0] targ_resp_rdata_i,
	input  logic [NB_TARG-1:0][1:0]        targ_resp_resp_i,
	input  logic [NB_TARG-1:0][TID_W-1:0]  targ_resp_id_i,

	input  logic [NB_TARG-1:0][ADDR_W-1:0] start_addr_i,
	input  logic [NB_TARG-1:0][ADDR_W-1:0] end_addr_i
);
	localparam int REQ_W = ADDR_W + 1 + DATA_W + STRB_W + ID_W;

	xbar_req_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W))  init_req_if  [NB_INIT] ();
	xbar_resp_if #(.DATA_W(DATA_W), .ID_W(ID_W))                   init_resp_if [NB_INIT] ();
	xbar_resp_if #(.DATA_W(DATA_W), .ID_W(ID_W))                   err_resp_if  [NB_INIT] ();
	xbar_req_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(TID_W)) targ_req_if  [NB_TARG] ();
	xbar_resp_if #(.DATA_W(DATA_W), .ID_W(TID_W))                  targ_resp_if [NB_TARG] ();

	logic [NB_INIT-1:0][NB_TARG-1:0] dec_valid;
	logic [NB_INIT-1:0][NB_TARG-1:0] dec_ready;
	logic [NB_TARG-1:0][NB_INIT-1:0] arb_valid;
	logic [NB_TARG-1:0][NB_INIT-1:0] arb_ready;
	logic [NB_INIT-1:0][REQ_W-1:0]   init_req_data;

	for (genvar i = 0; i < NB_INIT; i++) begin : g_init
		assign init_req_if[i].valid   = init_req_valid_i[i];
		assign init_req_if[i].payload = {init_req_addr_i[i], init_req_we_i[i],
			init_req_wdata_i[i], init_req_strb_i[i], init_req_id_i[i]};
		assign init_req_ready_o[i]    = init_req_if[i].ready;
		assign init_req_data[i]       = init_req_if[i].payload;

		assign init_resp_valid_o[i]   = init_resp_if[i].valid;
		assign init_resp_rdata_o[i]   = init_resp_if[i].payload.rdata;
		assign init_resp_resp_o[i]    = init_resp_if[i].payload.resp;
		assign init_resp_id_o[i]      = init_resp_if[i].payload.id;
		assign init_resp_if[i].ready  = init_resp_ready_i[i];

		// decoder view is per initiator, arbiter view is per target
		for (genvar t = 0; t < NB_TARG; t++) begin : g_cross
			assign arb_valid[t][i] = dec_valid[i][t];
			assign dec_ready[i][t] = arb_ready[t][i];
		end

		req_decoder #(
			.NB_TARG(NB_TARG),
			.ADDR_W (ADDR_W),
			.ID_W   (ID_W)
		) u_dec (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.init_req    (init_req_if[i]),
			.start_addr_i(start_addr_i),
			.end_addr_i  (end_addr_i),
			.sel_valid_o (dec_valid[i]),
			.sel_ready_i (dec_ready[i]),
			.err_resp    (err_resp_if[i])
		);
	end

	for (genvar t = 0; t < NB_TARG; t++) begin : g_targ
		assign targ_req_valid_o[t]    = targ_req_if[t].valid;
		assign targ_req_addr_o[t]     = targ_req_if[t].payload.addr;
		assign targ_req_we_o[t]       = targ_req_if[t].payload.we;
		assign targ_req_wdata_o[t]    = targ_req_if[t].payload.wdata;
		assign targ_req_strb_o[t]     = targ_req_if[t].payload.strb;
		assign targ_req_id_o[t]       = targ_req_if[t].payload.id;
		assign targ_req_if[t].ready   = targ_req_ready_i[t];

		assign targ_resp_if[t].valid   = targ_resp_valid_i[t];
		assign targ_resp_if[t].payload = {targ_resp_rdata_i[t], targ_resp_resp_i[t],
			targ_resp_id_i[t]};
		assign targ_resp_ready_o[t]    = targ_resp_if[t].ready;

		target_arbiter #(
			.NB_INIT(NB_INIT),
			.ADDR_W (ADDR_W),
			.DATA_W (DATA_W),
			.ID_W   (ID_W)
		) u_tarb (
			.clk            (clk),
			.rst_n_i        (rst_n_i),
			.req_valid_i    (arb_valid[t]),
			.req_ready_o    (arb_ready[t]),
			.init_req_data_i(init_req_data),
			.targ_req       (targ_req_if[t])
		);
	end

	resp_switch #(
		.NB_INIT(NB_INIT),
		.NB_TARG(NB_TARG),
		.DATA_W (DATA_W),
		.ID_W   (ID_W)
	) u_rsw (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.targ_resp(targ_resp_if),
		.err_resp (err_resp_if),
		.init_resp(init_resp_if)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f xbar_node_top.f --top-module tb_xbar_node -o sim_xbar
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_xbar)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

/* xbar_node_top.f */
rtl/xbar_cfg_pkg.sv
rtl/xbar_chan_pkg.sv
rtl/xbar_if.sv
rtl/rr_arbiter.sv
rtl/req_decoder.sv
rtl/target_arbiter.sv
rtl/resp_switch.sv
rtl/xbar_node_top.sv
bench/tb_target_model.sv
bench/tb_xbar_node.sv
